/* spi_core_pkg.sv */
//================================================
// Types for the SPI serial engine
// Byte, bit index and divider widths, the engine
// configuration struct and the FSM state encoding
//================================================
`default_nettype none

package spi_core_pkg;

    // One SPI byte on the wire
    typedef logic [7:0] data_t;

    // Bit position within a byte
    typedef logic [2:0] bit_idx_t;

    // Divider exponent, half-period is 2**clk_div clk cycles
    typedef logic [2:0] clk_div_t;

    // Divider counter, covers up to /128
    typedef logic [6:0] div_count_t;

    // Engine configuration as held in CTRL
    typedef struct packed {
        logic     cpol;
        logic     cpha;
        clk_div_t clk_div;
    } spi_cfg_t;

    // Shift FSM states
    typedef enum logic [1:0] {
        STATE_IDLE     = 2'b00,
        STATE_TRANSMIT = 2'b01,
        STATE_FINISH   = 2'b10
    } engine_state_t;

endpackage

`default_nettype wire

/* spi_regs_pkg.sv */
//================================================
// Register bus definitions for the SPI master
// Bus request and response structs, register
// offsets, field positions and reset values
//================================================
`default_nettype none

package spi_regs_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // Bytes left in a burst
    typedef logic [12:0] burst_count_t;

    // Host to peripheral
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
    } mmio_req_t;

    // Peripheral to host
    typedef struct packed {
        logic  ready;
        word_t rdata;
    } mmio_rsp_t;

    //================================================
    // Register offsets from the base address
    //================================================
    localparam addr_t OFFS_CTRL   = 32'h0000_0000;
    localparam addr_t OFFS_DATA   = 32'h0000_0004;
    localparam addr_t OFFS_STATUS = 32'h0000_0008;
    localparam addr_t OFFS_CS     = 32'h0000_000C;
    localparam addr_t OFFS_BURST  = 32'h0000_0010;

    // CTRL fields
    localparam int CTRL_CPOL_BIT = 0;
    localparam int CTRL_CPHA_BIT = 1;
    localparam int CTRL_DIV_LSB  = 2;
    localparam int CTRL_DIV_MSB  = 4;

    // STATUS fields
    localparam int STATUS_BUSY_BIT  = 0;
    localparam int STATUS_IDLE_BIT  = 1;
    localparam int STATUS_BURST_BIT = 2;

    // CS level bit
    localparam int CS_LEVEL_BIT = 0;

    // Reset values, slowest clock and CS released
    localparam logic [2:0] RST_CLK_DIV = 3'd7;
    localparam logic       RST_CS      = 1'b1;
    localparam logic       RST_CPOL    = 1'b0;
    localparam logic       RST_CPHA    = 1'b0;

endpackage

`default_nettype wire

/* spi_clk_div.sv */
//================================================
// Free-running power-of-two SCK divider
// One-cycle tick every 2**clk_div clk cycles
//================================================
`timescale 1ns/1ps
`default_nettype none

module spi_clk_div (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire spi_core_pkg::clk_div_t clk_div,
    output logic                       tick
);

    // Wrap value for the current exponent
    spi_core_pkg::div_count_t limit;
    spi_core_pkg::div_count_t count;

    // 2**clk_div - 1, computed one bit wider so /128 does not overflow
    assign limit = spi_core_pkg::div_count_t'((8'd1 << clk_div) - 8'd1);

    //================================================
    // Counter and tick
    //================================================
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count <= '0;
            tick  <= 1'b0;
        end else begin
            // Greater-or-equal so a smaller divider wraps at once
            if (count >= limit) begin
                count <= '0;
                tick  <= 1'b1;
            end else begin
                count <= count + 1'b1;
                tick  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* spi_shift_engine.sv */
//================================================
// SPI shift FSM
// Drives SCK and MOSI, samples MISO, all four modes
// Byte start by valid/ready, done pulse at the end
//================================================
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine (
    input  wire logic                   clk,
    input  wire logic                   resetn,
    input  wire spi_core_pkg::spi_cfg_t cfg,
    input  wire logic                   tick,
    input  wire logic                   start_valid,
    output logic                        start_ready,
    input  wire spi_core_pkg::data_t    tx_byte,
    output logic                        done,
    output spi_core_pkg::data_t         rx_byte,
    output logic                        spi_sck,
    output logic                        spi_mosi,
    input  wire logic                   spi_miso
);

    localparam spi_core_pkg::bit_idx_t LAST_BIT = 3'd7;

    spi_core_pkg::engine_state_t state;
    spi_core_pkg::data_t         shift_reg;
    spi_core_pkg::data_t         next_shift;
    spi_core_pkg::bit_idx_t      bit_cnt;

    // Low on the leading SCK edge, high on the trailing one
    logic sck_phase;
    // MISO held between the two edges in CPHA 0
    logic miso_cap;

    logic accept;
    logic lead_edge;
    logic trail_edge;
    logic shift_in;

    assign start_ready = (state == spi_core_pkg::STATE_IDLE);
    assign done        = (state == spi_core_pkg::STATE_FINISH);
    assign accept      = start_valid && start_ready;

    // Edges only count while shifting
    assign lead_edge  = (state == spi_core_pkg::STATE_TRANSMIT) && tick && !sck_phase;
    assign trail_edge = (state == spi_core_pkg::STATE_TRANSMIT) && tick && sck_phase;

    // CPHA 1 samples live MISO on the trailing edge
    assign shift_in   = cfg.cpha ? spi_miso : miso_cap;
    assign next_shift = {shift_reg[6:0], shift_in};

    //================================================
    // FSM, SCK and MOSI
    //================================================
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state     <= spi_core_pkg::STATE_IDLE;
            bit_cnt   <= '0;
            sck_phase <= 1'b0;
            spi_sck   <= 1'b0;
            spi_mosi  <= 1'b0;
            rx_byte   <= '0;
        end else begin
            case (state)
                spi_core_pkg::STATE_IDLE: begin
                    // Park SCK at its idle level
                    spi_sck   <= cfg.cpol;
                    sck_phase <= 1'b0;
                    if (accept) begin
                        bit_cnt <= '0;
                        state   <= spi_core_pkg::STATE_TRANSMIT;
                        // CPHA 0 needs the MSB before the first edge
                        if (!cfg.cpha) begin
                            spi_mosi <= tx_byte[7];
                        end
                    end
                end

                spi_core_pkg::STATE_TRANSMIT: begin
                    if (tick) begin
                        sck_phase <= ~sck_phase;
                        spi_sck   <= sck_phase ? cfg.cpol : ~cfg.cpol;
                    end
                    // Leading edge, CPHA 1 launches the current bit
                    if (lead_edge && cfg.cpha) begin
                        spi_mosi <= shift_reg[7];
                    end
                    if (trail_edge) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        // CPHA 0 launches the next bit here
                        if (!cfg.cpha && bit_cnt != LAST_BIT) begin
                            spi_mosi <= shift_reg[6];
                        end
                        // Eighth bit in, byte complete
                        if (bit_cnt == LAST_BIT) begin
                            rx_byte <= next_shift;
                            state   <= spi_core_pkg::STATE_FINISH;
                        end
                    end
                end

                spi_core_pkg::STATE_FINISH: begin
                    // One cycle, done is high
                    spi_sck <= cfg.cpol;
                    state   <= spi_core_pkg::STATE_IDLE;
                end

                default: begin
                    state <= spi_core_pkg::STATE_IDLE;
                end
            endcase
        end
    end

    //================================================
    // Shift register datapath
    //================================================
    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= tx_byte;
        end else if (trail_edge) begin
            shift_reg <= next_shift;
        end
        // Capture on the leading edge for CPHA 0
        if (lead_edge && !cfg.cpha) begin
            miso_cap <= spi_miso;
        end
    end

endmodule

`default_nettype wire

/* spi_regs.sv */
//================================================
// SPI master register block
// Bus decode, CTRL, CS, DATA start handshake,
// burst counter, interrupt and status readback
//================================================
`timescale 1ns/1ps
`default_nettype none

module spi_regs #(
    parameter spi_regs_pkg::addr_t BASE_ADDR = 32'h8000_0050
) (
    input  wire logic                    clk,
    input  wire logic                    resetn,
    input  wire spi_regs_pkg::mmio_req_t mmio_req,
    output spi_regs_pkg::mmio_rsp_t      mmio_rsp,
    output spi_core_pkg::spi_cfg_t       cfg,
    output logic                         start_valid,
    input  wire logic                    start_ready,
    output spi_core_pkg::data_t          tx_byte,
    input  wire logic                    done,
    input  wire spi_core_pkg::data_t     rx_byte,
    output logic                         spi_cs,
    output logic                         spi_irq
);

    // Absolute register addresses
    localparam spi_regs_pkg::addr_t ADDR_CTRL   = BASE_ADDR + spi_regs_pkg::OFFS_CTRL;
    localparam spi_regs_pkg::addr_t ADDR_DATA   = BASE_ADDR + spi_regs_pkg::OFFS_DATA;
    localparam spi_regs_pkg::addr_t ADDR_STATUS = BASE_ADDR + spi_regs_pkg::OFFS_STATUS;
    localparam spi_regs_pkg::addr_t ADDR_CS     = BASE_ADDR + spi_regs_pkg::OFFS_CS;
    localparam spi_regs_pkg::addr_t ADDR_BURST  = BASE_ADDR + spi_regs_pkg::OFFS_BURST;

    logic                       rsp_ready;
    spi_regs_pkg::word_t        rsp_rdata;
    spi_regs_pkg::word_t        rd_word;
    spi_regs_pkg::burst_count_t burst_count;
    logic                       burst_active;
    logic                       cs_reg;

    logic req_new;
    logic accept;
    logic busy;
    logic sel_ctrl;
    logic sel_data;
    logic sel_status;
    logic sel_cs;
    logic sel_burst;

    assign mmio_rsp.ready = rsp_ready;
    assign mmio_rsp.rdata = rsp_rdata;

    // New request, not yet answered and no start pending
    assign req_new = mmio_req.valid && !rsp_ready && !start_valid;
    assign accept  = start_valid && start_ready;

    // Engine shifting, or a byte waiting for it
    assign busy = !start_ready || start_valid;

    assign sel_ctrl   = (mmio_req.addr == ADDR_CTRL);
    assign sel_data   = (mmio_req.addr == ADDR_DATA);
    assign sel_status = (mmio_req.addr == ADDR_STATUS);
    assign sel_cs     = (mmio_req.addr == ADDR_CS);
    assign sel_burst  = (mmio_req.addr == ADDR_BURST);

    //================================================
    // Control registers and handshakes
    //================================================
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rsp_ready    <= 1'b0;
            start_valid  <= 1'b0;
            cfg          <= '{cpol:    spi_regs_pkg::RST_CPOL,
                              cpha:    spi_regs_pkg::RST_CPHA,
                              clk_div: spi_regs_pkg::RST_CLK_DIV};
            cs_reg       <= spi_regs_pkg::RST_CS;
            spi_cs       <= spi_regs_pkg::RST_CS;
            burst_count  <= '0;
            burst_active <= 1'b0;
            spi_irq      <= 1'b0;
        end else begin
            rsp_ready <= 1'b0;
            spi_irq   <= 1'b0;
            // Pin lags the register by one cycle
            spi_cs    <= cs_reg;

            // Engine took the byte, finish the DATA write
            if (accept) begin
                start_valid <= 1'b0;
                rsp_ready   <= 1'b1;
            end

            // Byte complete, interrupt only outside or at end of a burst
            if (done) begin
                if (!burst_active) begin
                    spi_irq <= 1'b1;
                end else if (burst_count == 13'd1) begin
                    burst_count  <= '0;
                    burst_active <= 1'b0;
                    spi_irq      <= 1'b1;
                end else begin
                    burst_count <= burst_count - 1'b1;
                end
            end

            if (req_new) begin
                if (mmio_req.write) begin
                    // DATA waits for the engine, all else answers now
                    if (sel_data) begin
                        start_valid <= 1'b1;
                    end else begin
                        rsp_ready <= 1'b1;
                    end
                    if (sel_ctrl) begin
                        cfg.cpol    <= mmio_req.wdata[spi_regs_pkg::CTRL_CPOL_BIT];
                        cfg.cpha    <= mmio_req.wdata[spi_regs_pkg::CTRL_CPHA_BIT];
                        cfg.clk_div <= mmio_req.wdata[spi_regs_pkg::CTRL_DIV_MSB:
                                                      spi_regs_pkg::CTRL_DIV_LSB];
                    end
                    if (sel_cs) begin
                        cs_reg <= mmio_req.wdata[spi_regs_pkg::CS_LEVEL_BIT];
                    end
                    // Bus write overrides a decrement in the same cycle
                    if (sel_burst) begin
                        burst_count  <= spi_regs_pkg::burst_count_t'(mmio_req.wdata);
                        burst_active <= (spi_regs_pkg::burst_count_t'(mmio_req.wdata) != '0);
                    end
                end else begin
                    rsp_ready <= 1'b1;
                end
            end
        end
    end

    //================================================
    // Read data assembly
    //================================================
    always_comb begin
        rd_word = '0;
        if (sel_ctrl) begin
            rd_word[spi_regs_pkg::CTRL_CPOL_BIT] = cfg.cpol;
            rd_word[spi_regs_pkg::CTRL_CPHA_BIT] = cfg.cpha;
            rd_word[spi_regs_pkg::CTRL_DIV_MSB:spi_regs_pkg::CTRL_DIV_LSB] = cfg.clk_div;
        end else if (sel_data) begin
            rd_word = spi_regs_pkg::word_t'(rx_byte);
        end else if (sel_status) begin
            rd_word[spi_regs_pkg::STATUS_BUSY_BIT]  = busy;
            rd_word[spi_regs_pkg::STATUS_IDLE_BIT]  = !busy;
            rd_word[spi_regs_pkg::STATUS_BURST_BIT] = burst_active;
        end else if (sel_cs) begin
            rd_word[spi_regs_pkg::CS_LEVEL_BIT] = cs_reg;
        end else if (sel_burst) begin
            rd_word = spi_regs_pkg::word_t'(burst_count);
        end
        // Unmapped reads stay zero
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (req_new && mmio_req.write && sel_data) begin
            tx_byte <= spi_core_pkg::data_t'(mmio_req.wdata);
        end
        if (req_new && !mmio_req.write) begin
            rsp_rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

/* spi_master.sv */
//================================================
// SPI master top level
// Register block, SCK divider and shift engine
//================================================
`timescale 1ns/1ps
`default_nettype none

module spi_master #(
    parameter spi_regs_pkg::addr_t BASE_ADDR = 32'h8000_0050
) (
    input  wire logic                    clk,
    input  wire logic                    resetn,
    input  wire spi_regs_pkg::mmio_req_t mmio_req,
    output spi_regs_pkg::mmio_rsp_t      mmio_rsp,
    output logic                         spi_sck,
    output logic                         spi_mosi,
    input  wire logic                    spi_miso,
    output logic                         spi_cs,
    output logic                         spi_irq
);

    // Configuration from CTRL
    spi_core_pkg::spi_cfg_t cfg;
    // Half-period strobe
    logic                   tick;

    // Byte start handshake
    logic                   start_valid;
    logic                   start_ready;
    spi_core_pkg::data_t    tx_byte;

    // Completion
    logic                   done;
    spi_core_pkg::data_t    rx_byte;

    spi_regs #(
        .BASE_ADDR (BASE_ADDR)
    ) i_spi_regs (
        .clk         (clk),
        .resetn      (resetn),
        .mmio_req    (mmio_req),
        .mmio_rsp    (mmio_rsp),
        .cfg         (cfg),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .tx_byte     (tx_byte),
        .done        (done),
        .rx_byte     (rx_byte),
        .spi_cs      (spi_cs),
        .spi_irq     (spi_irq)
    );

    spi_clk_div i_spi_clk_div (
        .clk     (clk),
        .resetn  (resetn),
        .clk_div (cfg.clk_div),
        .tick    (tick)
    );

    spi_shift_engine i_spi_shift_engine (
        .clk         (clk),
        .resetn      (resetn),
        .cfg         (cfg),
        .tick        (tick),
        .start_valid (start_valid),
        .start_ready (start_ready),
        .tx_byte     (tx_byte),
        .done        (done),
        .rx_byte     (rx_byte),
        .spi_sck     (spi_sck),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso)
    );

endmodule

`default_nettype wire

/* tb_spi_master.sv */
//================================================
// Random testbench for the SPI master
// Register bus driver, SPI slave model, IRQ monitor
// and checks for reset, modes, stall, burst, decode
//================================================
`timescale 1ns/1ps
`default_nettype none

module tb_spi_master;

    localparam spi_regs_pkg::addr_t BASE_ADDR = 32'h8000_0050;

    localparam spi_regs_pkg::addr_t ADDR_CTRL   = BASE_ADDR + spi_regs_pkg::OFFS_CTRL;
    localparam spi_regs_pkg::addr_t ADDR_DATA   = BASE_ADDR + spi_regs_pkg::OFFS_DATA;
    localparam spi_regs_pkg::addr_t ADDR_STATUS = BASE_ADDR + spi_regs_pkg::OFFS_STATUS;
    localparam spi_regs_pkg::addr_t ADDR_CS     = BASE_ADDR + spi_regs_pkg::OFFS_CS;
    localparam spi_regs_pkg::addr_t ADDR_BURST  = BASE_ADDR + spi_regs_pkg::OFFS_BURST;

    // Seed and wait limits in clk cycles
    localparam logic [31:0] SEED        = 32'd15;
    localparam int          BUS_TIMEOUT = 1000;
    localparam int          SCK_TIMEOUT = 200;
    localparam int          POLL_LIMIT  = 200;
    localparam int          NUM_SINGLE  = 6;
    localparam int          NUM_BURSTS  = 5;

    logic                    clk;
    logic                    resetn;
    spi_regs_pkg::mmio_req_t mmio_req;
    spi_regs_pkg::mmio_rsp_t mmio_rsp;
    logic                    spi_sck;
    logic                    spi_mosi;
    logic                    spi_miso;
    logic                    spi_cs;
    logic                    spi_irq;

    logic [31:0] rng_state;
    int          errors    = 0;
    int          timeouts  = 0;
    int          checks    = 0;
    int          irq_count = 0;
    int          sck_edges = 0;

    // Register model
    spi_regs_pkg::word_t exp_ctrl;
    logic                exp_cs;
    spi_regs_pkg::word_t exp_burst;

    spi_master #(
        .BASE_ADDR (BASE_ADDR)
    ) i_spi_master (
        .clk      (clk),
        .resetn   (resetn),
        .mmio_req (mmio_req),
        .mmio_rsp (mmio_rsp),
        .spi_sck  (spi_sck),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .spi_cs   (spi_cs),
        .spi_irq  (spi_irq)
    );

    //================================================
    // Clock and IRQ monitor
    //================================================
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // One count per high cycle of the one-cycle IRQ pulse
    always @(negedge clk) begin
        if (spi_irq) begin
            irq_count <= irq_count + 1;
        end
    end

    // xorshift32
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // CTRL word as the register map lays it out
    function automatic spi_regs_pkg::word_t ctrl_word(input logic cpol, input logic cpha,
                                                      input logic [2:0] div);
        spi_regs_pkg::word_t w;
        w = '0;
        w[spi_regs_pkg::CTRL_CPOL_BIT] = cpol;
        w[spi_regs_pkg::CTRL_CPHA_BIT] = cpha;
        w[spi_regs_pkg::CTRL_DIV_MSB:spi_regs_pkg::CTRL_DIV_LSB] = div;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t ns: gave up waiting for %s", $time, what);
    endtask

    //================================================
    // Bus driver
    //================================================
    // Called at a falling edge and returns at the falling edge that sees ready
    task automatic access_reg(input logic write, input spi_regs_pkg::addr_t addr,
                              input spi_regs_pkg::word_t wdata,
                              output spi_regs_pkg::word_t rdata);
        int waited;
        mmio_req.valid = 1'b1;
        mmio_req.write = write;
        mmio_req.addr  = addr;
        mmio_req.wdata = wdata;
        rdata  = '0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!mmio_rsp.ready && waited < BUS_TIMEOUT);
        if (mmio_rsp.ready) begin
            rdata = mmio_rsp.rdata;
        end else begin
            report_timeout("bus ready");
        end
        mmio_req = '0;
    endtask

    task automatic write_reg(input spi_regs_pkg::addr_t addr, input spi_regs_pkg::word_t data);
        spi_regs_pkg::word_t unused;
        access_reg(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input spi_regs_pkg::addr_t addr, output spi_regs_pkg::word_t data);
        access_reg(1'b0, addr, '0, data);
    endtask

    // Mode change and wait for SCK at its new idle level
    task automatic set_mode(input logic cpol, input logic cpha, input logic [2:0] div);
        int waited;
        exp_ctrl = ctrl_word(cpol, cpha, div);
        write_reg(ADDR_CTRL, exp_ctrl);
        waited = 0;
        while (spi_sck !== cpol && waited < SCK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (spi_sck !== cpol) begin
            report_timeout("SCK at its idle level");
        end
    endtask

    // Poll STATUS until not busy; SCK must rest at cpol then
    task automatic wait_idle(input logic cpol);
        spi_regs_pkg::word_t status;
        int                  polls;
        polls = 0;
        do begin
            read_reg(ADDR_STATUS, status);
            polls++;
        end while (!status[spi_regs_pkg::STATUS_IDLE_BIT] && polls < POLL_LIMIT);
        if (!status[spi_regs_pkg::STATUS_IDLE_BIT]) begin
            report_timeout("STATUS not busy");
        end else begin
            check_value("STATUS.busy", status[spi_regs_pkg::STATUS_BUSY_BIT], 1'b0);
            check_value("spi_sck", spi_sck, cpol);
        end
    endtask

    //================================================
    // SPI slave model
    //================================================
    // Edges seen at falling clk edges; sample on leading edge for CPHA 0,
    // on trailing edge for CPHA 1, and drive MISO on the other edge
    task automatic slave_transfer(input logic cpol, input logic cpha,
                                  input spi_core_pkg::data_t reply,
                                  output spi_core_pkg::data_t received);
        logic                prev_sck;
        logic                leading;
        int                  edges;
        int                  waited;
        spi_core_pkg::data_t out_bits;
        received = '0;
        out_bits = reply;
        prev_sck = cpol;
        edges    = 0;
        // CPHA 0 shows the MSB before the first edge
        if (!cpha) begin
            spi_miso = out_bits[7];
            out_bits = out_bits << 1;
        end
        while (edges < 16) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (spi_sck === prev_sck && waited < SCK_TIMEOUT);
            if (spi_sck === prev_sck) begin
                report_timeout("an SCK edge");
                break;
            end
            prev_sck = spi_sck;
            edges++;
            sck_edges++;
            leading = (spi_sck != cpol);
            if (leading ^ cpha) begin
                received = {received[6:0], spi_mosi};
            end else begin
                spi_miso = out_bits[7];
                out_bits = out_bits << 1;
            end
        end
    endtask

    // One byte through DATA with a random reply from the slave
    task automatic run_byte(input logic cpol, input logic cpha);
        logic [31:0]         rnd;
        spi_core_pkg::data_t tx;
        spi_core_pkg::data_t reply;
        spi_core_pkg::data_t seen;
        spi_regs_pkg::word_t rd;
        rnd   = next_random();
        tx    = rnd[7:0];
        reply = rnd[15:8];
        fork
            slave_transfer(cpol, cpha, reply, seen);
            write_reg(ADDR_DATA, spi_regs_pkg::word_t'(tx));
        join
        wait_idle(cpol);
        check_value("MOSI byte", seen, tx);
        read_reg(ADDR_DATA, rd);
        check_value("DATA", rd, reply);
    endtask

    //================================================
    // Main sequence
    //================================================
    initial begin
        spi_regs_pkg::word_t rd;
        logic [31:0]         rnd;
        logic                cpol;
        logic                cpha;
        int                  irq_before;
        int                  edges_base;
        int                  edges_at_ack;
        int                  n;
        spi_core_pkg::data_t b1;
        spi_core_pkg::data_t b2;
        spi_core_pkg::data_t r1;
        spi_core_pkg::data_t r2;
        spi_core_pkg::data_t seen1;
        spi_core_pkg::data_t seen2;

        resetn    = 1'b0;
        mmio_req  = '0;
        spi_miso  = 1'b0;
        rng_state = SEED;
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        // Reset values
        exp_ctrl  = ctrl_word(spi_regs_pkg::RST_CPOL, spi_regs_pkg::RST_CPHA,
                              spi_regs_pkg::RST_CLK_DIV);
        exp_cs    = spi_regs_pkg::RST_CS;
        exp_burst = '0;
        read_reg(ADDR_CTRL, rd);
        check_value("CTRL", rd, exp_ctrl);
        read_reg(ADDR_CS, rd);
        check_value("CS", rd, spi_regs_pkg::word_t'(exp_cs));
        check_value("spi_cs", spi_cs, exp_cs);
        read_reg(ADDR_STATUS, rd);
        check_value("STATUS", rd, 32'd1 << spi_regs_pkg::STATUS_IDLE_BIT);
        read_reg(ADDR_BURST, rd);
        check_value("BURST", rd, exp_burst);

        // Random CTRL and CS readback
        repeat (8) begin
            rnd = next_random();
            write_reg(ADDR_CTRL, rnd);
            exp_ctrl = ctrl_word(rnd[spi_regs_pkg::CTRL_CPOL_BIT],
                                 rnd[spi_regs_pkg::CTRL_CPHA_BIT],
                                 rnd[spi_regs_pkg::CTRL_DIV_MSB:spi_regs_pkg::CTRL_DIV_LSB]);
            read_reg(ADDR_CTRL, rd);
            check_value("CTRL", rd, exp_ctrl);
            rnd = next_random();
            write_reg(ADDR_CS, rnd);
            exp_cs = rnd[spi_regs_pkg::CS_LEVEL_BIT];
            // Pin follows one cycle after the register
            @(negedge clk);
            check_value("spi_cs", spi_cs, exp_cs);
            read_reg(ADDR_CS, rd);
            check_value("CS", rd, spi_regs_pkg::word_t'(exp_cs));
        end

        // Select the slave for the transfers
        exp_cs = 1'b0;
        write_reg(ADDR_CS, '0);
        @(negedge clk);
        check_value("spi_cs", spi_cs, exp_cs);

        // Single bytes in all four modes
        for (int mode = 0; mode < 4; mode++) begin
            rnd  = next_random();
            cpol = mode[0];
            cpha = mode[1];
            set_mode(cpol, cpha, {1'b0, rnd[1:0]});
            repeat (NUM_SINGLE) begin
                irq_before = irq_count;
                run_byte(cpol, cpha);
                check_value("IRQ pulses", irq_count - irq_before, 1);
            end
        end

        // Second DATA write stalls behind the first byte
        rnd  = next_random();
        cpol = rnd[0];
        cpha = rnd[1];
        set_mode(cpol, cpha, {1'b0, rnd[3:2]});
        b1 = rnd[15:8];
        b2 = rnd[23:16];
        r1 = rnd[31:24];
        rnd = next_random();
        r2 = rnd[7:0];
        irq_before   = irq_count;
        edges_base   = sck_edges;
        edges_at_ack = 0;
        fork
            begin
                slave_transfer(cpol, cpha, r1, seen1);
                slave_transfer(cpol, cpha, r2, seen2);
            end
            begin
                write_reg(ADDR_DATA, spi_regs_pkg::word_t'(b1));
                read_reg(ADDR_STATUS, rd);
                check_value("STATUS.busy", rd[spi_regs_pkg::STATUS_BUSY_BIT], 1'b1);
                write_reg(ADDR_DATA, spi_regs_pkg::word_t'(b2));
                edges_at_ack = sck_edges - edges_base;
            end
        join
        checks++;
        assert (edges_at_ack >= 16) else begin
            $display("Second DATA write acknowledged after only %0d SCK edges", edges_at_ack);
            errors++;
        end
        wait_idle(cpol);
        check_value("MOSI byte", seen1, b1);
        check_value("MOSI byte", seen2, b2);
        read_reg(ADDR_DATA, rd);
        check_value("DATA", rd, r2);
        check_value("IRQ pulses", irq_count - irq_before, 2);

        // Bursts of 1 to 5 bytes with one IRQ at the end
        repeat (NUM_BURSTS) begin
            rnd  = next_random();
            cpol = rnd[0];
            cpha = rnd[1];
            set_mode(cpol, cpha, {1'b0, rnd[3:2]});
            n = 1 + int'(rnd[15:8] % 5);
            write_reg(ADDR_BURST, n);
            read_reg(ADDR_STATUS, rd);
            check_value("STATUS.burst", rd[spi_regs_pkg::STATUS_BURST_BIT], 1'b1);
            for (int k = 1; k <= n; k++) begin
                irq_before = irq_count;
                run_byte(cpol, cpha);
                read_reg(ADDR_BURST, rd);
                check_value("BURST", rd, n - k);
                read_reg(ADDR_STATUS, rd);
                check_value("STATUS.burst", rd[spi_regs_pkg::STATUS_BURST_BIT], k < n);
                check_value("IRQ pulses", irq_count - irq_before, (k == n) ? 1 : 0);
            end
        end

        // Unmapped offsets ack writes, change nothing and read zero
        exp_cs = 1'b1;
        write_reg(ADDR_CS, 32'd1);
        repeat (4) begin
            rnd = next_random();
            write_reg(BASE_ADDR + 32'h14 + {rnd[7:2], 2'b00}, next_random());
            read_reg(BASE_ADDR + 32'h14 + {rnd[7:2], 2'b00}, rd);
            check_value("unmapped read", rd, '0);
            read_reg(ADDR_CTRL, rd);
            check_value("CTRL", rd, exp_ctrl);
            read_reg(ADDR_CS, rd);
            check_value("CS", rd, spi_regs_pkg::word_t'(exp_cs));
            read_reg(ADDR_BURST, rd);
            check_value("BURST", rd, exp_burst);
        end

        repeat (4) @(negedge clk);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
spi_core_pkg.sv
spi_regs_pkg.sv
spi_clk_div.sv
spi_shift_engine.sv
spi_regs.sv
spi_master.sv
tb_spi_master.sv

/* Makefile */
# Verilator build and run for the SPI master testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
